//--- common/bmu_pkg.sv
// Bit-manipulation unit package with opcodes, operator encodings and shared records

package bmu_pkg;

  ////////////////////////////////////////////////////////////////////////////
  // Major opcodes
  ////////////////////////////////////////////////////////////////////////////

  localparam logic [6:0] OPCODE_OP    = 7'h33;
  localparam logic [6:0] OPCODE_OPIMM = 7'h13;

  // Legal subset combinations, chosen at build time
  typedef enum logic [1:0] {
    B_NONE,
    ZBA_ZBB,
    ZBA_ZBB_ZBS,
    ZBA_ZBB_ZBC_ZBS
  } b_ext_e;

  ////////////////////////////////////////////////////////////////////////////
  // ALU operators
  ////////////////////////////////////////////////////////////////////////////

  typedef enum logic [4:0] {
    // Zba
    ALU_B_SH1ADD,
    ALU_B_SH2ADD,
    ALU_B_SH3ADD,
    // Zbb
    ALU_B_MIN,
    ALU_B_MINU,
    ALU_B_MAX,
    ALU_B_MAXU,
    ALU_B_ANDN,
    ALU_B_ORN,
    ALU_B_XNOR,
    ALU_B_ROL,
    ALU_B_ROR,
    ALU_B_ZEXT_H,
    ALU_B_CLZ,
    ALU_B_CTZ,
    ALU_B_CPOP,
    ALU_B_ORC_B,
    ALU_B_REV8,
    ALU_B_SEXT_B,
    ALU_B_SEXT_H,
    // Zbc
    ALU_B_CLMUL,
    ALU_B_CLMULH,
    ALU_B_CLMULR,
    // Zbs
    ALU_B_BSET,
    ALU_B_BCLR,
    ALU_B_BINV,
    ALU_B_BEXT,
    ALU_NONE      // Illegal or unsupported word
  } alu_op_e;

  // Second operand source
  typedef enum logic [1:0] {
    OP_B_REG,     // rs2 value
    OP_B_IMM,     // shamt field, instr[24:20]
    OP_B_NONE     // Unary operation, operand forced to zero
  } op_b_sel_e;

  ////////////////////////////////////////////////////////////////////////////
  // Records passed between blocks
  ////////////////////////////////////////////////////////////////////////////

  typedef struct packed {
    logic [31:0] instr;
    logic [31:0] rs1;
    logic [31:0] rs2;
  } issue_t;

  typedef struct packed {
    alu_op_e   alu_op;
    op_b_sel_e op_b_sel;
    logic      illegal;
  } b_ctrl_t;

  typedef struct packed {
    logic [31:0] result;
    logic        illegal;
  } result_t;

  // Decoder output for anything not executed
  localparam b_ctrl_t B_CTRL_ILLEGAL = '{
    alu_op:   ALU_NONE,
    op_b_sel: OP_B_NONE,
    illegal:  1'b1
  };

endpackage

//--- source/bmu_b_decoder.sv
// B-extension decoder, maps OP and OP-IMM words onto ALU control
`timescale 1ns/1ps

module bmu_b_decoder #(
  parameter bmu_pkg::b_ext_e B_EXT = bmu_pkg::B_NONE
) (
  input  logic [31:0]      instr_i,
  output bmu_pkg::b_ctrl_t ctrl_o
);

  localparam bit RV32B_ZBA = (B_EXT != bmu_pkg::B_NONE);
  localparam bit RV32B_ZBB = (B_EXT != bmu_pkg::B_NONE);
  localparam bit RV32B_ZBS = (B_EXT == bmu_pkg::ZBA_ZBB_ZBS) ||
                             (B_EXT == bmu_pkg::ZBA_ZBB_ZBC_ZBS);
  localparam bit RV32B_ZBC = (B_EXT == bmu_pkg::ZBA_ZBB_ZBC_ZBS);

  bmu_pkg::alu_op_e   dec_op;   // Matched operator, before subset check
  bmu_pkg::op_b_sel_e dec_bsel;
  logic               dec_en;   // Operator belongs to an enabled subset
  logic [14:0]        funct;    // {funct7, rs2 field, funct3}

  assign funct = {instr_i[31:25], instr_i[24:20], instr_i[14:12]};

  ////////////////////////////////////////////////////////////////////////////
  // Pattern match
  ////////////////////////////////////////////////////////////////////////////

  always_comb begin
    dec_op = bmu_pkg::ALU_NONE;
    unique case (instr_i[6:0])
      bmu_pkg::OPCODE_OP: begin
        unique casez (funct)
          {7'b0010000, 5'b?????, 3'b010}: dec_op = bmu_pkg::ALU_B_SH1ADD;
          {7'b0010000, 5'b?????, 3'b100}: dec_op = bmu_pkg::ALU_B_SH2ADD;
          {7'b0010000, 5'b?????, 3'b110}: dec_op = bmu_pkg::ALU_B_SH3ADD;
          {7'b0000101, 5'b?????, 3'b100}: dec_op = bmu_pkg::ALU_B_MIN;
          {7'b0000101, 5'b?????, 3'b101}: dec_op = bmu_pkg::ALU_B_MINU;
          {7'b0000101, 5'b?????, 3'b110}: dec_op = bmu_pkg::ALU_B_MAX;
          {7'b0000101, 5'b?????, 3'b111}: dec_op = bmu_pkg::ALU_B_MAXU;
          {7'b0100000, 5'b?????, 3'b111}: dec_op = bmu_pkg::ALU_B_ANDN;
          {7'b0100000, 5'b?????, 3'b110}: dec_op = bmu_pkg::ALU_B_ORN;
          {7'b0100000, 5'b?????, 3'b100}: dec_op = bmu_pkg::ALU_B_XNOR;
          {7'b0110000, 5'b?????, 3'b001}: dec_op = bmu_pkg::ALU_B_ROL;
          {7'b0110000, 5'b?????, 3'b101}: dec_op = bmu_pkg::ALU_B_ROR;
          {7'b0000100, 5'b00000, 3'b100}: dec_op = bmu_pkg::ALU_B_ZEXT_H; // rs2 field must be x0
          {7'b0000101, 5'b?????, 3'b001}: dec_op = bmu_pkg::ALU_B_CLMUL;
          {7'b0000101, 5'b?????, 3'b011}: dec_op = bmu_pkg::ALU_B_CLMULH;
          {7'b0000101, 5'b?????, 3'b010}: dec_op = bmu_pkg::ALU_B_CLMULR;
          {7'b0010100, 5'b?????, 3'b001}: dec_op = bmu_pkg::ALU_B_BSET;
          {7'b0100100, 5'b?????, 3'b001}: dec_op = bmu_pkg::ALU_B_BCLR;
          {7'b0110100, 5'b?????, 3'b001}: dec_op = bmu_pkg::ALU_B_BINV;
          {7'b0100100, 5'b?????, 3'b101}: dec_op = bmu_pkg::ALU_B_BEXT;
          default:                        dec_op = bmu_pkg::ALU_NONE;
        endcase
      end
      bmu_pkg::OPCODE_OPIMM: begin
        unique casez (funct)
          {7'b0110000, 5'b00000, 3'b001}: dec_op = bmu_pkg::ALU_B_CLZ;
          {7'b0110000, 5'b00001, 3'b001}: dec_op = bmu_pkg::ALU_B_CTZ;
          {7'b0110000, 5'b00010, 3'b001}: dec_op = bmu_pkg::ALU_B_CPOP;
          {7'b0110000, 5'b00100, 3'b001}: dec_op = bmu_pkg::ALU_B_SEXT_B;
          {7'b0110000, 5'b00101, 3'b001}: dec_op = bmu_pkg::ALU_B_SEXT_H;
          {7'b0010100, 5'b00111, 3'b101}: dec_op = bmu_pkg::ALU_B_ORC_B;
          {7'b0110100, 5'b11000, 3'b101}: dec_op = bmu_pkg::ALU_B_REV8;
          {7'b0110000, 5'b?????, 3'b101}: dec_op = bmu_pkg::ALU_B_ROR;  // rori
          {7'b0010100, 5'b?????, 3'b001}: dec_op = bmu_pkg::ALU_B_BSET; // bseti
          {7'b0100100, 5'b?????, 3'b001}: dec_op = bmu_pkg::ALU_B_BCLR; // bclri
          {7'b0110100, 5'b?????, 3'b001}: dec_op = bmu_pkg::ALU_B_BINV; // binvi
          {7'b0100100, 5'b?????, 3'b101}: dec_op = bmu_pkg::ALU_B_BEXT; // bexti
          default:                        dec_op = bmu_pkg::ALU_NONE;
        endcase
      end
      default: dec_op = bmu_pkg::ALU_NONE; // Not a B opcode
    endcase
  end

  ////////////////////////////////////////////////////////////////////////////
  // Subset check and operand b source
  ////////////////////////////////////////////////////////////////////////////

  always_comb begin
    unique case (dec_op)
      bmu_pkg::ALU_B_SH1ADD, bmu_pkg::ALU_B_SH2ADD, bmu_pkg::ALU_B_SH3ADD:
        dec_en = RV32B_ZBA;
      bmu_pkg::ALU_B_CLMUL, bmu_pkg::ALU_B_CLMULH, bmu_pkg::ALU_B_CLMULR:
        dec_en = RV32B_ZBC;
      bmu_pkg::ALU_B_BSET, bmu_pkg::ALU_B_BCLR, bmu_pkg::ALU_B_BINV, bmu_pkg::ALU_B_BEXT:
        dec_en = RV32B_ZBS;
      bmu_pkg::ALU_NONE: dec_en = 1'b0;
      default:           dec_en = RV32B_ZBB; // Remaining operators are Zbb
    endcase
  end

  always_comb begin
    unique case (dec_op)
      bmu_pkg::ALU_B_ZEXT_H, bmu_pkg::ALU_B_CLZ, bmu_pkg::ALU_B_CTZ, bmu_pkg::ALU_B_CPOP,
      bmu_pkg::ALU_B_ORC_B, bmu_pkg::ALU_B_REV8, bmu_pkg::ALU_B_SEXT_B, bmu_pkg::ALU_B_SEXT_H:
        dec_bsel = bmu_pkg::OP_B_NONE;
      default:
        dec_bsel = (instr_i[6:0] == bmu_pkg::OPCODE_OPIMM) ? bmu_pkg::OP_B_IMM
                                                           : bmu_pkg::OP_B_REG;
    endcase
  end

  always_comb begin
    if (dec_en) begin
      ctrl_o.alu_op   = dec_op;
      ctrl_o.op_b_sel = dec_bsel;
      ctrl_o.illegal  = 1'b0;
    end else begin
      ctrl_o = bmu_pkg::B_CTRL_ILLEGAL;
    end
  end

endmodule

//--- bmu_alu/bmu_alu.sv
// B-extension ALU, computes Zba, Zbb, Zbc and Zbs results
`timescale 1ns/1ps

module bmu_alu (
  input  bmu_pkg::alu_op_e op_i,
  input  logic [31:0]      a_i,
  input  logic [31:0]      b_i,
  output logic [31:0]      result_o
);

  logic [4:0]  sh;          // Shift amount and bit index
  logic [63:0] rot_l;
  logic [63:0] rot_r;
  logic [31:0] bit_mask;
  logic [5:0]  clz_cnt;
  logic [5:0]  ctz_cnt;
  logic [5:0]  cpop_cnt;
  logic [63:0] clmul_prod;  // Full carry-less product

  assign sh       = b_i[4:0];
  assign rot_l    = {a_i, a_i} << sh;
  assign rot_r    = {a_i, a_i} >> sh;
  assign bit_mask = 32'h1 << sh;

  ////////////////////////////////////////////////////////////////////////////
  // Counting and carry-less multiply
  ////////////////////////////////////////////////////////////////////////////

  always_comb begin
    clz_cnt  = 6'd32;
    ctz_cnt  = 6'd32;
    cpop_cnt = '0;
    for (int i = 0; i < 32; i++) begin
      if (a_i[i]) clz_cnt = 6'(31 - i);       // Highest set bit wins
      if (a_i[31-i]) ctz_cnt = 6'(31 - i);    // Lowest set bit wins
      cpop_cnt = cpop_cnt + 6'(a_i[i]);
    end
  end

  // One partial term per bit of b
  always_comb begin
    clmul_prod = '0;
    for (int i = 0; i < 32; i++) begin
      if (b_i[i]) clmul_prod = clmul_prod ^ ({32'b0, a_i} << i);
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // Result select
  ////////////////////////////////////////////////////////////////////////////

  always_comb begin
    unique case (op_i)
      bmu_pkg::ALU_B_SH1ADD: result_o = {a_i[30:0], 1'b0} + b_i;
      bmu_pkg::ALU_B_SH2ADD: result_o = {a_i[29:0], 2'b0} + b_i;
      bmu_pkg::ALU_B_SH3ADD: result_o = {a_i[28:0], 3'b0} + b_i;
      bmu_pkg::ALU_B_MIN:    result_o = ($signed(a_i) < $signed(b_i)) ? a_i : b_i;
      bmu_pkg::ALU_B_MINU:   result_o = (a_i < b_i) ? a_i : b_i;
      bmu_pkg::ALU_B_MAX:    result_o = ($signed(a_i) < $signed(b_i)) ? b_i : a_i;
      bmu_pkg::ALU_B_MAXU:   result_o = (a_i < b_i) ? b_i : a_i;
      bmu_pkg::ALU_B_ANDN:   result_o = a_i & ~b_i;
      bmu_pkg::ALU_B_ORN:    result_o = a_i | ~b_i;
      bmu_pkg::ALU_B_XNOR:   result_o = ~(a_i ^ b_i);
      bmu_pkg::ALU_B_ROL:    result_o = rot_l[63:32];
      bmu_pkg::ALU_B_ROR:    result_o = rot_r[31:0];
      bmu_pkg::ALU_B_ZEXT_H: result_o = {16'b0, a_i[15:0]};
      bmu_pkg::ALU_B_CLZ:    result_o = {26'b0, clz_cnt};
      bmu_pkg::ALU_B_CTZ:    result_o = {26'b0, ctz_cnt};
      bmu_pkg::ALU_B_CPOP:   result_o = {26'b0, cpop_cnt};
      bmu_pkg::ALU_B_ORC_B: begin
        for (int i = 0; i < 4; i++) begin
          result_o[i*8 +: 8] = (|a_i[i*8 +: 8]) ? 8'hff : 8'h00;
        end
      end
      bmu_pkg::ALU_B_REV8:   result_o = {a_i[7:0], a_i[15:8], a_i[23:16], a_i[31:24]};
      bmu_pkg::ALU_B_SEXT_B: result_o = {{24{a_i[7]}}, a_i[7:0]};
      bmu_pkg::ALU_B_SEXT_H: result_o = {{16{a_i[15]}}, a_i[15:0]};
      bmu_pkg::ALU_B_CLMUL:  result_o = clmul_prod[31:0];
      bmu_pkg::ALU_B_CLMULH: result_o = clmul_prod[63:32];
      bmu_pkg::ALU_B_CLMULR: result_o = clmul_prod[62:31];
      bmu_pkg::ALU_B_BSET:   result_o = a_i | bit_mask;
      bmu_pkg::ALU_B_BCLR:   result_o = a_i & ~bit_mask;
      bmu_pkg::ALU_B_BINV:   result_o = a_i ^ bit_mask;
      bmu_pkg::ALU_B_BEXT:   result_o = {31'b0, a_i[sh]};
      default:               result_o = '0; // ALU_NONE
    endcase
  end

endmodule

//--- source/bmu_in_fifo.sv
// Input buffer of issued instructions, sized to the input credit count
`timescale 1ns/1ps

module bmu_in_fifo #(
  parameter int DEPTH = 4
) (
  input  logic            clk,
  input  logic            arst_n_i,
  input  logic            push_i,
  input  bmu_pkg::issue_t push_data_i,
  input  logic            pop_i,
  output bmu_pkg::issue_t pop_data_o,
  output logic            empty_o
);

  localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
  localparam int CNT_W = $clog2(DEPTH + 1);

  bmu_pkg::issue_t  mem [DEPTH];
  logic [PTR_W-1:0] wr_ptr_q;
  logic [PTR_W-1:0] rd_ptr_q;
  logic [CNT_W-1:0] count_q;   // Entries held

  always_ff @(posedge clk or negedge arst_n_i) begin
    if (!arst_n_i) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
    end else begin
      if (push_i) begin
        wr_ptr_q <= (wr_ptr_q == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr_q + 1'b1;
      end
      if (pop_i) begin
        rd_ptr_q <= (rd_ptr_q == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr_q + 1'b1;
      end
      count_q <= count_q + CNT_W'(push_i) - CNT_W'(pop_i);
    end
  end

  // Storage
  always_ff @(posedge clk) begin
    if (push_i) mem[wr_ptr_q] <= push_data_i;
  end

  assign pop_data_o = mem[rd_ptr_q];
  assign empty_o    = (count_q == '0);

endmodule

//--- source/bmu_top.sv
// Bit-manipulation execute unit top level with credit flow control on both sides
`timescale 1ns/1ps

module bmu_top #(
  parameter bmu_pkg::b_ext_e B_EXT       = bmu_pkg::ZBA_ZBB_ZBC_ZBS,
  parameter int              IN_DEPTH    = 4,
  parameter int              OUT_CREDITS = 2
) (
  input  logic             clk,
  input  logic             arst_n_i,
  input  logic             in_valid_i,
  input  bmu_pkg::issue_t  in_data_i,
  output logic             in_credit_o,
  output logic             out_valid_o,
  output bmu_pkg::result_t out_data_o,
  input  logic             out_credit_i
);

  localparam int CNT_W = $clog2(OUT_CREDITS + 1);

  bmu_pkg::issue_t  pop_data;
  logic             fifo_empty;
  logic             pop;
  bmu_pkg::b_ctrl_t ctrl;
  logic [31:0]      op_b;
  logic [31:0]      alu_res;
  logic [CNT_W-1:0] out_cred_q;     // Output credits not yet spent
  logic             in_credit_q;
  logic             out_valid_q;
  bmu_pkg::result_t out_data_q;

  bmu_in_fifo #(.DEPTH(IN_DEPTH)) bmu_in_fifo_inst (
    .clk         (clk),
    .arst_n_i    (arst_n_i),
    .push_i      (in_valid_i),
    .push_data_i (in_data_i),
    .pop_i       (pop),
    .pop_data_o  (pop_data),
    .empty_o     (fifo_empty)
  );

  // A returning credit can be spent in the cycle it arrives
  assign pop = !fifo_empty && ((out_cred_q != '0) || out_credit_i);

  bmu_b_decoder #(.B_EXT(B_EXT)) bmu_b_decoder_inst (
    .instr_i (pop_data.instr),
    .ctrl_o  (ctrl)
  );

  always_comb begin
    unique case (ctrl.op_b_sel)
      bmu_pkg::OP_B_REG: op_b = pop_data.rs2;
      bmu_pkg::OP_B_IMM: op_b = {27'b0, pop_data.instr[24:20]}; // shamt
      default:           op_b = '0;
    endcase
  end

  bmu_alu bmu_alu_inst (
    .op_i     (ctrl.alu_op),
    .a_i      (pop_data.rs1),
    .b_i      (op_b),
    .result_o (alu_res)
  );

  //////////////////////////////////////////////////////////////////////////
  // Output stage and credit counter
  //////////////////////////////////////////////////////////////////////////

  // Credit is taken on the edge that raises out_valid_o
  always_ff @(posedge clk or negedge arst_n_i) begin
    if (!arst_n_i) begin
      out_cred_q  <= CNT_W'(OUT_CREDITS);
      out_valid_q <= 1'b0;
      in_credit_q <= 1'b0;
    end else begin
      out_cred_q  <= out_cred_q + CNT_W'(out_credit_i) - CNT_W'(pop);
      out_valid_q <= pop;
      in_credit_q <= pop;   // One input credit per popped entry
    end
  end

  always_ff @(posedge clk) begin
    if (pop) begin
      out_data_q.result  <= ctrl.illegal ? 32'b0 : alu_res;
      out_data_q.illegal <= ctrl.illegal;
    end
  end

  assign out_valid_o = out_valid_q;
  assign out_data_o  = out_data_q;
  assign in_credit_o = in_credit_q;

endmodule

//--- verif/bmu_tb_clk.sv
// Testbench clock generator, free-running square wave
`timescale 1ns/1ps

module bmu_tb_clk #(
  parameter int PERIOD_NS = 100
) (
  output logic clk_o
);

  initial clk_o = 1'b0;

  always #(PERIOD_NS / 2) clk_o = ~clk_o;  // Half period per phase

endmodule

//--- verif/bmu_assert.sv
// Credit protocol assertions for the execute unit, bound to its top level
`timescale 1ns/1ps

module bmu_assert #(
  parameter int IN_DEPTH    = 4,
  parameter int OUT_CREDITS = 2
) (
  input logic clk,
  input logic arst_n_i,
  input logic in_valid_i,
  input logic pop_i,
  input logic in_credit_i,
  input logic out_valid_i,
  input logic out_credit_i
);

  int fill_q;   // Buffer occupancy seen from the push and pop strobes
  int avail_q;  // Output credits as seen on the ports

  always_ff @(posedge clk or negedge arst_n_i) begin
    if (!arst_n_i) begin
      fill_q  <= 0;
      avail_q <= OUT_CREDITS;
    end else begin
      fill_q  <= fill_q + int'(in_valid_i) - int'(pop_i);
      avail_q <= avail_q + int'(out_credit_i) - int'(out_valid_i);
    end
  end

  no_push_when_full: assert property (@(posedge clk) disable iff (!arst_n_i)
    in_valid_i |-> (fill_q < IN_DEPTH))
    else $error("instruction pushed into a full input buffer");

  // A result needs a held credit or one returning in the same cycle
  no_send_without_credit: assert property (@(posedge clk) disable iff (!arst_n_i)
    out_valid_i |-> ((avail_q > 0) || out_credit_i))
    else $error("result sent with no output credit");

  quiet_in_reset: assert property (@(posedge clk)
    !arst_n_i |-> (!in_credit_i && !out_valid_i))
    else $error("credit or valid strobe active during reset");

endmodule

bind bmu_top bmu_assert #(
  .IN_DEPTH    (IN_DEPTH),
  .OUT_CREDITS (OUT_CREDITS)
) bmu_assert_inst (
  .clk          (clk),
  .arst_n_i     (arst_n_i),
  .in_valid_i   (in_valid_i),
  .pop_i        (pop),
  .in_credit_i  (in_credit_o),
  .out_valid_i  (out_valid_o),
  .out_credit_i (out_credit_i)
);

//--- verif/bmu_tb.sv
// Testbench for the bit-manipulation execute unit with a reference model and credit play
`timescale 1ns/1ps

module bmu_tb;

  localparam bmu_pkg::b_ext_e B_EXT  = bmu_pkg::ZBA_ZBB_ZBS;
  localparam int IN_DEPTH       = 4;
  localparam int OUT_CREDITS    = 2;
  localparam int RESET_CYCLES   = 10;
  localparam int N_TXN          = 500;
  localparam int TIMEOUT_CYCLES = 20 * N_TXN + RESET_CYCLES;
  localparam bit ZBS_ON = (B_EXT == bmu_pkg::ZBA_ZBB_ZBS) ||
                          (B_EXT == bmu_pkg::ZBA_ZBB_ZBC_ZBS);
  localparam bit ZBC_ON = (B_EXT == bmu_pkg::ZBA_ZBB_ZBC_ZBS);

  logic             clk;
  logic             arst_n;
  logic             in_valid;
  bmu_pkg::issue_t  in_data;
  logic             in_credit;
  logic             out_valid;
  bmu_pkg::result_t out_data;
  logic             out_credit;

  logic        run_en = 1'b0;       // Master and consumer active
  logic [32:0] exp_q [$];           // {illegal, result} in issue order
  logic [31:0] tmpl_q [$];          // Encodings of the listed instructions
  bit          free_q [$];          // rs2 field of the template is random
  int          in_credits    = IN_DEPTH;
  int          issued        = 0;
  int          credit_pulses = 0;
  int          received      = 0;
  int          outstanding   = 0;   // Results not yet credited back
  int          stall_left    = 0;
  int          cycles        = 0;

  bmu_tb_clk #(.PERIOD_NS(100)) bmu_tb_clk_inst (.clk_o(clk));

  bmu_top #(
    .B_EXT       (B_EXT),
    .IN_DEPTH    (IN_DEPTH),
    .OUT_CREDITS (OUT_CREDITS)
  ) bmu_top_inst (
    .clk          (clk),
    .arst_n_i     (arst_n),
    .in_valid_i   (in_valid),
    .in_data_i    (in_data),
    .in_credit_o  (in_credit),
    .out_valid_o  (out_valid),
    .out_data_o   (out_data),
    .out_credit_i (out_credit)
  );

  //////////////////////////////////////////////////////////////////////////////
  // Reference model
  //////////////////////////////////////////////////////////////////////////////

  function automatic logic signed_less(input logic [31:0] x, input logic [31:0] y);
    return (x ^ 32'h8000_0000) < (y ^ 32'h8000_0000);  // Bias the sign bit
  endfunction

  function automatic logic [31:0] rot_right(input logic [31:0] x, input int n);
    return (x >> n) | (x << (32 - n));
  endfunction

  function automatic logic [31:0] lead_zeros(input logic [31:0] x);
    int n;
    n = 0;
    while (n < 32 && !x[31 - n]) n++;
    return 32'(n);
  endfunction

  function automatic logic [31:0] trail_zeros(input logic [31:0] x);
    int n;
    n = 0;
    while (n < 32 && !x[n]) n++;
    return 32'(n);
  endfunction

  function automatic logic [31:0] pop_count(input logic [31:0] x);
    int n;
    n = 0;
    for (int i = 0; i < 32; i++) n += int'(x[i]);
    return 32'(n);
  endfunction

  function automatic logic [31:0] or_combine(input logic [31:0] x);
    logic [31:0] y;
    for (int i = 0; i < 4; i++) y[8*i +: 8] = {8{|x[8*i +: 8]}};
    return y;
  endfunction

  // Partial terms taken over the bits of x
  function automatic logic [63:0] clmul_ref(input logic [31:0] x, input logic [31:0] y);
    logic [63:0] p;
    p = '0;
    for (int i = 0; i < 32; i++) begin
      if (x[i]) p ^= (64'(y) << i);
    end
    return p;
  endfunction

  // Kind 0 sets, 1 clears, 2 inverts, 3 extracts
  function automatic logic [31:0] bit_op(input int kind, input logic [31:0] x,
                                         input logic [4:0] n);
    logic [31:0] y;
    y = x;
    case (kind)
      0:       y[n] = 1'b1;
      1:       y[n] = 1'b0;
      2:       y[n] = ~x[n];
      default: y = {31'b0, x[n]};
    endcase
    return y;
  endfunction

  function automatic logic [32:0] model_exec(input logic [31:0] instr, input logic [31:0] a,
                                             input logic [31:0] rs2);
    logic [6:0]  f7;
    logic [4:0]  r2;
    logic [2:0]  f3;
    logic [63:0] cl;
    logic [31:0] res;
    logic        ok;
    logic        is_zbs;
    logic        is_zbc;
    f7  = instr[31:25];
    r2  = instr[24:20];
    f3  = instr[14:12];
    res = '0;
    ok  = 1'b1;
    cl  = clmul_ref(a, rs2);
    if (instr[6:0] == bmu_pkg::OPCODE_OP) begin
      case ({f7, f3})
        {7'b0010000, 3'b010}: res = (a << 1) + rs2;
        {7'b0010000, 3'b100}: res = (a << 2) + rs2;
        {7'b0010000, 3'b110}: res = (a << 3) + rs2;
        {7'b0000101, 3'b100}: res = signed_less(a, rs2) ? a : rs2;
        {7'b0000101, 3'b101}: res = (a < rs2) ? a : rs2;
        {7'b0000101, 3'b110}: res = signed_less(a, rs2) ? rs2 : a;
        {7'b0000101, 3'b111}: res = (a < rs2) ? rs2 : a;
        {7'b0100000, 3'b111}: res = a & ~rs2;
        {7'b0100000, 3'b110}: res = a | ~rs2;
        {7'b0100000, 3'b100}: res = a ^ ~rs2;
        {7'b0110000, 3'b001}: res = rot_right(a, (32 - int'(rs2[4:0])) % 32);
        {7'b0110000, 3'b101}: res = rot_right(a, int'(rs2[4:0]));
        {7'b0000101, 3'b001}: res = cl[31:0];
        {7'b0000101, 3'b011}: res = cl[63:32];
        {7'b0000101, 3'b010}: res = cl[62:31];
        {7'b0010100, 3'b001}: res = bit_op(0, a, rs2[4:0]);
        {7'b0100100, 3'b001}: res = bit_op(1, a, rs2[4:0]);
        {7'b0110100, 3'b001}: res = bit_op(2, a, rs2[4:0]);
        {7'b0100100, 3'b101}: res = bit_op(3, a, rs2[4:0]);
        {7'b0000100, 3'b100}: begin
          res = {16'h0, a[15:0]};
          ok  = (r2 == 5'd0);   // zext.h needs rs2 field x0
        end
        default: ok = 1'b0;
      endcase
    end else if (instr[6:0] == bmu_pkg::OPCODE_OPIMM) begin
      case ({f7, f3})
        {7'b0110000, 3'b001}: begin
          case (r2)
            5'd0:    res = lead_zeros(a);
            5'd1:    res = trail_zeros(a);
            5'd2:    res = pop_count(a);
            5'd4:    res = 32'($signed(a[7:0]));
            5'd5:    res = 32'($signed(a[15:0]));
            default: ok = 1'b0;
          endcase
        end
        {7'b0010100, 3'b101}: begin
          res = or_combine(a);
          ok  = (r2 == 5'd7);
        end
        {7'b0110100, 3'b101}: begin
          res = {a[7:0], a[15:8], a[23:16], a[31:24]};
          ok  = (r2 == 5'd24);
        end
        {7'b0110000, 3'b101}: res = rot_right(a, int'(r2));
        {7'b0010100, 3'b001}: res = bit_op(0, a, r2);
        {7'b0100100, 3'b001}: res = bit_op(1, a, r2);
        {7'b0110100, 3'b001}: res = bit_op(2, a, r2);
        {7'b0100100, 3'b101}: res = bit_op(3, a, r2);
        default:              ok  = 1'b0;
      endcase
    end else begin
      ok = 1'b0;  // Not a B opcode
    end
    // Subset membership is the same for both opcodes apart from Zbc
    is_zbs = ((f3 == 3'b001) && (f7 inside {7'b0010100, 7'b0100100, 7'b0110100})) ||
             ((f3 == 3'b101) && (f7 == 7'b0100100));
    is_zbc = (instr[6:0] == bmu_pkg::OPCODE_OP) && (f7 == 7'b0000101) &&
             (f3 inside {3'b001, 3'b010, 3'b011});
    ok = ok && (ZBS_ON || !is_zbs) && (ZBC_ON || !is_zbc);
    return {!ok, ok ? res : 32'h0};
  endfunction

  //////////////////////////////////////////////////////////////////////////////
  // Checking and failure reporting
  //////////////////////////////////////////////////////////////////////////////

  task automatic check_value(input string what, input logic [31:0] got,
                             input logic [31:0] exp);
    if (got !== exp) begin
      $display("error at %0t ns: %s is %h, expected %h", $time, what, got, exp);
      $display("Simulation failed");
      $fatal(1, "mismatch on %s", what);
    end
  endtask

  task automatic fail_run(input string msg);
    $display("%s at %0t ns", msg, $time);
    $display("Simulation failed");
    $fatal(1, "run stopped");
  endtask

  //////////////////////////////////////////////////////////////////////////////
  // Stimulus
  //////////////////////////////////////////////////////////////////////////////

  task automatic add_tmpl(input logic [6:0] f7, input logic [4:0] r2, input logic [2:0] f3,
                          input logic [6:0] opc, input bit free);
    tmpl_q.push_back({f7, r2, 5'b0, f3, 5'b0, opc});
    free_q.push_back(free);
  endtask

  task automatic build_table();
    add_tmpl(7'b0010000, 5'd0, 3'b010, bmu_pkg::OPCODE_OP, 1);     // sh1add
    add_tmpl(7'b0010000, 5'd0, 3'b100, bmu_pkg::OPCODE_OP, 1);
    add_tmpl(7'b0010000, 5'd0, 3'b110, bmu_pkg::OPCODE_OP, 1);
    add_tmpl(7'b0000101, 5'd0, 3'b100, bmu_pkg::OPCODE_OP, 1);     // min
    add_tmpl(7'b0000101, 5'd0, 3'b101, bmu_pkg::OPCODE_OP, 1);
    add_tmpl(7'b0000101, 5'd0, 3'b110, bmu_pkg::OPCODE_OP, 1);
    add_tmpl(7'b0000101, 5'd0, 3'b111, bmu_pkg::OPCODE_OP, 1);
    add_tmpl(7'b0100000, 5'd0, 3'b111, bmu_pkg::OPCODE_OP, 1);     // andn
    add_tmpl(7'b0100000, 5'd0, 3'b110, bmu_pkg::OPCODE_OP, 1);
    add_tmpl(7'b0100000, 5'd0, 3'b100, bmu_pkg::OPCODE_OP, 1);
    add_tmpl(7'b0110000, 5'd0, 3'b001, bmu_pkg::OPCODE_OP, 1);     // rol
    add_tmpl(7'b0110000, 5'd0, 3'b101, bmu_pkg::OPCODE_OP, 1);
    add_tmpl(7'b0000100, 5'd0, 3'b100, bmu_pkg::OPCODE_OP, 0);     // zext.h
    add_tmpl(7'b0000100, 5'd0, 3'b100, bmu_pkg::OPCODE_OP, 1);     // Mostly illegal
    add_tmpl(7'b0000101, 5'd0, 3'b001, bmu_pkg::OPCODE_OP, 1);     // clmul
    add_tmpl(7'b0000101, 5'd0, 3'b011, bmu_pkg::OPCODE_OP, 1);
    add_tmpl(7'b0000101, 5'd0, 3'b010, bmu_pkg::OPCODE_OP, 1);
    add_tmpl(7'b0010100, 5'd0, 3'b001, bmu_pkg::OPCODE_OP, 1);     // bset
    add_tmpl(7'b0100100, 5'd0, 3'b001, bmu_pkg::OPCODE_OP, 1);
    add_tmpl(7'b0110100, 5'd0, 3'b001, bmu_pkg::OPCODE_OP, 1);
    add_tmpl(7'b0100100, 5'd0, 3'b101, bmu_pkg::OPCODE_OP, 1);
    add_tmpl(7'b0110000, 5'd0, 3'b001, bmu_pkg::OPCODE_OPIMM, 0);  // clz
    add_tmpl(7'b0110000, 5'd1, 3'b001, bmu_pkg::OPCODE_OPIMM, 0);
    add_tmpl(7'b0110000, 5'd2, 3'b001, bmu_pkg::OPCODE_OPIMM, 0);
    add_tmpl(7'b0110000, 5'd4, 3'b001, bmu_pkg::OPCODE_OPIMM, 0);
    add_tmpl(7'b0110000, 5'd5, 3'b001, bmu_pkg::OPCODE_OPIMM, 0);
    add_tmpl(7'b0010100, 5'd7, 3'b101, bmu_pkg::OPCODE_OPIMM, 0);  // orc.b
    add_tmpl(7'b0110100, 5'd24, 3'b101, bmu_pkg::OPCODE_OPIMM, 0); // rev8
    add_tmpl(7'b0110000, 5'd0, 3'b101, bmu_pkg::OPCODE_OPIMM, 1);  // rori
    add_tmpl(7'b0010100, 5'd0, 3'b001, bmu_pkg::OPCODE_OPIMM, 1);
    add_tmpl(7'b0100100, 5'd0, 3'b001, bmu_pkg::OPCODE_OPIMM, 1);
    add_tmpl(7'b0110100, 5'd0, 3'b001, bmu_pkg::OPCODE_OPIMM, 1);
    add_tmpl(7'b0100100, 5'd0, 3'b101, bmu_pkg::OPCODE_OPIMM, 1);  // bexti
  endtask

  function automatic logic [31:0] pick_operand();
    case ($urandom % 8)
      0:       return 32'h0000_0000;
      1:       return 32'hffff_ffff;
      2:       return 32'h8000_0000;
      default: return $urandom;
    endcase
  endfunction

  task automatic issue_one();
    bmu_pkg::issue_t item;
    int unsigned     k;
    k = $urandom % 100;
    if (k < 70) begin
      k = $urandom % tmpl_q.size();
      item.instr = tmpl_q[k] | ($urandom & 32'h000f_8f80);  // rs1 and rd fields
      if (free_q[k]) item.instr[24:20] = 5'($urandom);
    end else if (k < 85) begin
      item.instr = $urandom;                            // Mostly other opcodes
    end else begin
      item.instr      = $urandom;                       // Random funct fields
      item.instr[6:0] = ($urandom % 2) ? bmu_pkg::OPCODE_OP : bmu_pkg::OPCODE_OPIMM;
    end
    item.rs1 = pick_operand();
    item.rs2 = pick_operand();
    in_data  = item;
    in_valid = 1'b1;
    exp_q.push_back(model_exec(item.instr, item.rs1, item.rs2));
  endtask

  //////////////////////////////////////////////////////////////////////////////
  // Consumer
  //////////////////////////////////////////////////////////////////////////////

  task automatic take_result();
    logic [32:0] exp;
    if (exp_q.size() == 0) begin
      fail_run("a result came out with no instruction in flight");
    end else begin
      exp = exp_q.pop_front();
      check_value("result", out_data.result, exp[31:0]);
      check_value("illegal flag", 32'(out_data.illegal), 32'(exp[32]));
      received++;
      outstanding++;
      if (outstanding > OUT_CREDITS) fail_run("more results outstanding than output credits");
    end
  endtask

  // Random credit returns with occasional long stalls
  task automatic return_credit();
    if (stall_left > 0) begin
      stall_left--;
    end else if ($urandom % 64 == 0) begin
      stall_left = 16 + int'($urandom % 24);
    end else if (outstanding > 0 && $urandom % 3 == 0) begin
      out_credit = 1'b1;
      outstanding--;
    end
  endtask

  // Master side
  always @(negedge clk) begin
    if (run_en) begin
      in_valid = 1'b0;
      if (in_credit) begin
        in_credits++;
        credit_pulses++;
      end
      if (in_credits > 0 && issued < N_TXN && $urandom % 4 != 0) begin
        issue_one();
        in_credits--;
        issued++;
      end
    end
  end

  // Consumer side
  always @(negedge clk) begin
    if (run_en) begin
      out_credit = 1'b0;
      if (out_valid) take_result();
      return_credit();
    end
  end

  always @(posedge clk) begin
    cycles <= cycles + 1;
    if (cycles >= TIMEOUT_CYCLES) fail_run("timeout, not all transactions completed");
  end

  initial begin
    void'($urandom(32'hb92a));
    arst_n     = 1'b0;
    in_valid   = 1'b0;
    in_data    = '0;
    out_credit = 1'b0;
    build_table();
    repeat (RESET_CYCLES) @(posedge clk);
    @(negedge clk);
    arst_n = 1'b1;
    @(posedge clk);
    run_en = 1'b1;
    wait (received == N_TXN);
    repeat (2) @(negedge clk);
    check_value("input credit pulses", 32'(credit_pulses), 32'(issued));
    $display("Simulation completed successfully");
    $finish;
  end

endmodule

//--- bmu.f
common/bmu_pkg.sv
source/bmu_b_decoder.sv
bmu_alu/bmu_alu.sv
source/bmu_in_fifo.sv
source/bmu_top.sv
verif/bmu_tb_clk.sv
verif/bmu_assert.sv
verif/bmu_tb.sv

//--- Makefile
# Verilator build and run for the bit-manipulation execute unit

VERILATOR ?= verilator
TOP       ?= bmu_tb
FILELIST  ?= bmu.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing --assert -Wno-fatal

SOURCES   := $(shell grep -v '^+' $(FILELIST))
SIM       := $(BUILD_DIR)/V$(TOP)

.PHONY: all run clean

all: run

$(SIM): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

run: $(SIM)
	./$(SIM)

clean:
	rm -rf $(BUILD_DIR)
